//--- filelist.f
usb_pkg.sv
usb_ep_bulk.sv
usb_ep0.sv
usb_protocol.sv
tb_clock.sv
tb_usb_protocol.sv

//--- Bender.yml
package:
  name: usb_protocol

dependencies: {}

sources:
  # design
  - usb_pkg.sv
  - usb_ep_bulk.sv
  - usb_ep0.sv
  - usb_protocol.sv

  # testbench
  - target: test
    files:
      - tb_clock.sv
      - tb_usb_protocol.sv

//--- tb_usb_protocol.sv
// testbench for the usb protocol layer
// applies a table of control, bulk and error transactions to the DUT
// and checks replies, buffer contents and status flags
module tb_usb_protocol import usb_pkg::*; ();

	localparam int buf_aw     = 9;
	localparam int len_w      = buf_aw + 1;
	localparam int wait_limit = 20;

	localparam logic [3:0] pid_in  = 4'b1001;
	localparam logic [3:0] pid_out = 4'b0001;

	localparam logic [2:0] op_setup      = 3'd0;
	localparam logic [2:0] op_data_out   = 3'd1;
	localparam logic [2:0] op_bulk_write = 3'd2;
	localparam logic [2:0] op_bulk_read  = 3'd3;
	localparam logic [2:0] op_bad_ep     = 3'd4;

	typedef struct packed {
		logic [2:0]       op;
		logic [3:0]       endp;
		logic [7:0]       b_request;
		logic [15:0]      w_value;
		logic [15:0]      w_length;
		logic [len_w-1:0] exp_len;
		logic [6:0]       exp_addr;
		logic             exp_err;
	} row_t;

	logic              phy_clk;
	logic              reset_2;
	logic              xfer_in;
	logic              xfer_in_ok;
	logic              xfer_out;
	logic              xfer_out_ok;
	logic              xfer_query;
	logic [3:0]        xfer_endp;
	logic [3:0]        xfer_pid;
	logic [buf_aw-1:0] buf_in_addr;
	logic [7:0]        buf_in_data;
	logic              buf_in_wren;
	logic              buf_in_ready;
	logic [buf_aw-1:0] buf_out_addr;
	logic [7:0]        buf_out_q;
	logic              buf_out_ready;
	logic [buf_aw:0]   buf_out_len;
	logic [buf_aw-1:0] ext_buf_in_addr;
	logic [7:0]        ext_buf_in_data;
	logic              ext_buf_in_wren;
	logic              ext_buf_in_ready;
	logic [buf_aw-1:0] ext_buf_out_addr;
	logic [7:0]        ext_buf_out_q;
	logic              ext_buf_out_ready;
	logic              ext_xfer_read;
	logic              ext_xfer_write;
	logic [buf_aw:0]   ext_xfer_len;
	logic [6:0]        dev_addr;
	logic              err_missed_ep_ready;

	row_t       rows [16];
	int         n_rows;
	logic [7:0] payload [2 ** buf_aw];
	int         seed_val;

	tb_clock clk_gen (
		.phy_clk (phy_clk),
		.reset_2 (reset_2)
	);

	usb_protocol #(
		.buf_aw (buf_aw)
	) DUT (.*);

	//////////////////////////////////////////////////////////////////////
	// reporting
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge phy_clk);
	endtask

	task automatic add_row(input logic [2:0] op, input logic [3:0] endp,
		input logic [7:0] req, input logic [15:0] wval, input logic [15:0] wlen,
		input int len, input logic [6:0] addr, input logic err);
		row_t r;
		r.op        = op;
		r.endp      = endp;
		r.b_request = req;
		r.w_value   = wval;
		r.w_length  = wlen;
		r.exp_len   = len_w'(len);
		r.exp_addr  = addr;
		r.exp_err   = err;
		rows[n_rows] = r;
		n_rows++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// transactions
	//////////////////////////////////////////////////////////////////////

	// host sends an 8 byte setup packet to endpoint 0
	task automatic send_setup(input row_t r);
		logic [7:0] pkt [setup_len];
		int i;
		pkt[0] = (r.b_request == req_get_descriptor) ? 8'h80 : 8'h00;
		pkt[1] = r.b_request;
		pkt[2] = r.w_value[7:0];
		pkt[3] = r.w_value[15:8];
		pkt[4] = 8'h00;
		pkt[5] = 8'h00;
		pkt[6] = r.w_length[7:0];
		pkt[7] = r.w_length[15:8];
		xfer_endp = r.endp;
		xfer_pid  = pid_setup;
		xfer_in   = 1'b1;
		@(negedge phy_clk);
		// endpoint 0 always takes host data
		check_equal("buf_in_ready", buf_in_ready, 1);
		for (i = 0; i < setup_len; i++) begin
			buf_in_addr = buf_aw'(i);
			buf_in_data = pkt[i];
			buf_in_wren = 1'b1;
			@(negedge phy_clk);
		end
		buf_in_wren = 1'b0;
		xfer_in     = 1'b0;
		idle_cycles(3);
	endtask

	// host reads the reply of endpoint 0, then acks it
	task automatic fetch_reply(input row_t r, input logic [6:0] old_addr);
		int i;
		xfer_endp    = r.endp;
		xfer_pid     = pid_in;
		xfer_out     = 1'b1;
		buf_out_addr = '0;
		@(negedge phy_clk);
		check_equal("buf_out_ready", buf_out_ready, 1);
		check_equal("buf_out_len", buf_out_len, r.exp_len);
		for (i = 0; i < r.exp_len; i++) begin
			buf_out_addr = buf_aw'(i);
			@(negedge phy_clk);
			check_equal("buf_out_q", buf_out_q, dev_desc[i]);
		end
		// even an empty IN lasts past the cycle the endpoint is selected
		@(negedge phy_clk);
		xfer_out = 1'b0;
		idle_cycles(3);
		// address must wait for the ack
		check_equal("dev_addr", dev_addr, old_addr);
		xfer_out_ok = 1'b1;
		@(negedge phy_clk);
		xfer_out_ok = 1'b0;
		@(negedge phy_clk);
	endtask

	// host fills endpoint 2, external side drains it
	task automatic fill_bulk_out(input row_t r);
		int i;
		int n;
		logic seen;
		n = r.exp_len;
		for (i = 0; i < n; i++) begin
			payload[i] = 8'($urandom);
		end
		xfer_endp = r.endp;
		xfer_pid  = pid_out;
		xfer_in   = 1'b1;
		@(negedge phy_clk);
		for (i = 0; i < n; i++) begin
			buf_in_addr = buf_aw'(i);
			buf_in_data = payload[i];
			buf_in_wren = 1'b1;
			@(negedge phy_clk);
		end
		buf_in_wren = 1'b0;
		xfer_in     = 1'b0;
		seen = 1'b0;
		for (i = 0; i < wait_limit && !seen; i++) begin
			@(negedge phy_clk);
			seen = ext_xfer_write;
		end
		assert (seen) else begin
			$display("ext_xfer_write never pulsed after the host data on endpoint 2");
			abort_run();
		end
		check_equal("ext_xfer_len", ext_xfer_len, n);
		@(negedge phy_clk);
		check_equal("ext_xfer_write", ext_xfer_write, 0);
		for (i = 0; i < n; i++) begin
			ext_buf_out_addr = buf_aw'(i);
			@(negedge phy_clk);
			check_equal("ext_buf_out_q", ext_buf_out_q, payload[i]);
		end
		idle_cycles(3);
	endtask

	// external side fills endpoint 1 on request, host reads it
	task automatic drain_bulk_in(input row_t r);
		int i;
		int n;
		logic seen;
		n = r.exp_len;
		for (i = 0; i < n; i++) begin
			payload[i] = 8'($urandom);
		end
		xfer_endp    = r.endp;
		xfer_pid     = pid_in;
		xfer_out     = 1'b1;
		buf_out_addr = '0;
		seen = 1'b0;
		for (i = 0; i < wait_limit && !seen; i++) begin
			@(negedge phy_clk);
			seen = ext_xfer_read;
		end
		assert (seen) else begin
			$display("ext_xfer_read never pulsed after the host asked endpoint 1 for data");
			abort_run();
		end
		for (i = 0; i < n; i++) begin
			ext_buf_in_addr = buf_aw'(i);
			ext_buf_in_data = payload[i];
			ext_buf_in_wren = 1'b1;
			@(negedge phy_clk);
		end
		ext_buf_in_wren = 1'b0;
		check_equal("buf_out_ready", buf_out_ready, 1);
		check_equal("buf_out_len", buf_out_len, n);
		for (i = 0; i < n; i++) begin
			buf_out_addr = buf_aw'(i);
			@(negedge phy_clk);
			check_equal("buf_out_q", buf_out_q, payload[i]);
		end
		xfer_out = 1'b0;
		idle_cycles(3);
	endtask

	// unsupported endpoint, nothing is steered
	task automatic probe_bad_endp(input row_t r);
		xfer_endp    = r.endp;
		xfer_pid     = pid_in;
		xfer_out     = 1'b1;
		buf_out_addr = '0;
		idle_cycles(2);
		check_equal("buf_in_ready", buf_in_ready, 0);
		check_equal("buf_out_ready", buf_out_ready, 0);
		check_equal("buf_out_len", buf_out_len, 0);
		check_equal("buf_out_q", buf_out_q, 0);
		check_equal("ext_xfer_read", ext_xfer_read, 0);
		xfer_out = 1'b0;
		idle_cycles(3);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int k;
		logic [6:0] cur_addr;
		xfer_in           = 1'b0;
		xfer_in_ok        = 1'b0;
		xfer_out          = 1'b0;
		xfer_out_ok       = 1'b0;
		xfer_query        = 1'b0;
		xfer_endp         = '0;
		xfer_pid          = '0;
		buf_in_addr       = '0;
		buf_in_data       = '0;
		buf_in_wren       = 1'b0;
		buf_out_addr      = '0;
		ext_buf_in_addr   = '0;
		ext_buf_in_data   = '0;
		ext_buf_in_wren   = 1'b0;
		ext_buf_in_ready  = 1'b1;
		ext_buf_out_addr  = '0;
		ext_buf_out_ready = 1'b1;
		seed_val = $urandom(66788);
		n_rows   = 0;

		// op, endpoint, request, wValue, wLength, length, address, error flag
		add_row(op_setup, ep_ctrl, req_set_address, 16'h002a, 16'd0, 0, 7'h00, 1'b0);
		add_row(op_data_out, ep_ctrl, 8'h00, 16'h0000, 16'd0, 0, 7'h2a, 1'b0);
		add_row(op_setup, ep_ctrl, req_get_descriptor, {desc_device, 8'h00}, 16'd64, 0, 7'h2a, 1'b0);
		add_row(op_data_out, ep_ctrl, 8'h00, 16'h0000, 16'd0, 18, 7'h2a, 1'b0);
		add_row(op_setup, ep_ctrl, req_get_descriptor, {desc_device, 8'h00}, 16'd8, 0, 7'h2a, 1'b0);
		add_row(op_data_out, ep_ctrl, 8'h00, 16'h0000, 16'd0, 8, 7'h2a, 1'b0);
		add_row(op_bulk_write, ep_bulk_out, 8'h00, 16'h0000, 16'd0, 37, 7'h2a, 1'b0);
		add_row(op_bulk_read, ep_bulk_in, 8'h00, 16'h0000, 16'd0, 23, 7'h2a, 1'b0);
		add_row(op_bulk_write, ep_bulk_out, 8'h00, 16'h0000, 16'd0, 5, 7'h2a, 1'b0);
		add_row(op_bad_ep, 4'd5, 8'h00, 16'h0000, 16'd0, 0, 7'h2a, 1'b0);
		// two setups with no reply fetched in between
		add_row(op_setup, ep_ctrl, req_get_descriptor, {desc_device, 8'h00}, 16'd18, 0, 7'h2a, 1'b0);
		add_row(op_setup, ep_ctrl, req_get_descriptor, {desc_device, 8'h00}, 16'd18, 0, 7'h2a, 1'b1);

		for (k = 0; k < wait_limit && reset_2 !== 1'b1; k++) begin
			@(negedge phy_clk);
		end
		assert (reset_2 === 1'b1) else begin
			$display("reset was never released");
			abort_run();
		end
		idle_cycles(2);
		cur_addr = '0;

		for (k = 0; k < n_rows; k++) begin
			case (rows[k].op)
				op_setup:      send_setup(rows[k]);
				op_data_out:   fetch_reply(rows[k], cur_addr);
				op_bulk_write: fill_bulk_out(rows[k]);
				op_bulk_read:  drain_bulk_in(rows[k]);
				default:       probe_bad_endp(rows[k]);
			endcase
			check_equal("dev_addr", dev_addr, rows[k].exp_addr);
			check_equal("err_missed_ep_ready", err_missed_ep_ready, rows[k].exp_err);
			cur_addr = rows[k].exp_addr;
		end

		$display("test passed");
		$finish;
	end

endmodule

//--- tb_clock.sv
// testbench clock and reset
// 100 unit clock period, reset held low for the first four cycles
module tb_clock (
	output logic phy_clk,
	output logic reset_2
);

	initial begin
		phy_clk = 1'b0;
		forever begin
			#50 phy_clk = ~phy_clk;
		end
	end

	initial begin
		reset_2 = 1'b0;
		repeat (4) @(posedge phy_clk);
		// release away from the active edge
		@(negedge phy_clk);
		reset_2 = 1'b1;
	end

endmodule

//--- usb_protocol.sv
// usb full speed device protocol layer
// dispatches packet layer transactions to the control endpoint and two
// bulk endpoints, and signals the external side to fill or drain them
module usb_protocol import usb_pkg::*; #(
	parameter int buf_aw = 9
) (
	input  logic              phy_clk,
	input  logic              reset_2,

	// packet layer transactions
	input  logic              xfer_in,
	input  logic              xfer_in_ok,
	input  logic              xfer_out,
	input  logic              xfer_out_ok,
	input  logic              xfer_query,
	input  logic [3:0]        xfer_endp,
	input  logic [3:0]        xfer_pid,

	// packet layer buffer ports
	input  logic [buf_aw-1:0] buf_in_addr,
	input  logic [7:0]        buf_in_data,
	input  logic              buf_in_wren,
	output logic              buf_in_ready,
	input  logic [buf_aw-1:0] buf_out_addr,
	output logic [7:0]        buf_out_q,
	output logic              buf_out_ready,
	output logic [buf_aw:0]   buf_out_len,

	// external side
	input  logic [buf_aw-1:0] ext_buf_in_addr,
	input  logic [7:0]        ext_buf_in_data,
	input  logic              ext_buf_in_wren,
	input  logic              ext_buf_in_ready,
	input  logic [buf_aw-1:0] ext_buf_out_addr,
	output logic [7:0]        ext_buf_out_q,
	input  logic              ext_buf_out_ready,
	output logic              ext_xfer_read,
	output logic              ext_xfer_write,
	output logic [buf_aw:0]   ext_xfer_len,

	output logic [6:0]        dev_addr,
	output logic              err_missed_ep_ready
);

	localparam int len_w = buf_aw + 1;

	typedef enum logic [2:0] {
		st_rst,
		st_idle,
		st_xfer_in,
		st_xfer_out,
		st_query,
		st_done
	} state_t;

	state_t      state;
	ep_sel_t     sel;
	logic [3:0]  endp_last;

	logic        xfer_in_1;
	logic        xfer_out_1;
	logic        xfer_query_1;
	logic        in_rise;
	logic        out_rise;
	logic        query_rise;

	// endpoint 0
	logic        ep0_xfer_in;
	logic        ep0_xfer_out;
	logic        ep0_xfer_out_ok;
	logic [3:0]  ep0_xfer_pid;
	logic        ep0_buf_in_wren;
	logic [7:0]  ep0_buf_out_addr;
	logic        ep0_xfer_ready;
	logic [7:0]  ep0_buf_out_q;
	logic [6:0]  ep0_buf_out_len;
	logic        ep0_ready_1;
	logic        ep0_ready_rise;
	logic        ep0_ready_latch;
	logic        ep0_out_1;

	// bulk endpoints
	logic        ep1_start;
	logic [7:0]  ep1_rd_q;
	logic [buf_aw:0] ep1_cnt;
	logic        ep2_start;
	logic        ep2_wr_en;

	function automatic ep_sel_t endp_to_sel(input logic [3:0] endp);
		ep_sel_t s;
		case (endp)
			ep_ctrl:     s = sel_ep0;
			ep_bulk_in:  s = sel_ep1;
			ep_bulk_out: s = sel_ep2;
			default:     s = sel_free;
		endcase
		return s;
	endfunction

	assign in_rise    = xfer_in & ~xfer_in_1;
	assign out_rise   = xfer_out & ~xfer_out_1;
	assign query_rise = xfer_query & ~xfer_query_1;

	// a new fill starts when a transaction opens on a bulk endpoint
	assign ep1_start = out_rise && (state == st_idle) && (xfer_endp == ep_bulk_in);
	assign ep2_start = in_rise && (state == st_idle) && (xfer_endp == ep_bulk_out);

	//////////////////////////////////////////////////////////////////////
	// transaction dispatcher
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			state          <= st_rst;
			sel            <= sel_free;
			endp_last      <= '0;
			xfer_in_1      <= 1'b0;
			xfer_out_1     <= 1'b0;
			xfer_query_1   <= 1'b0;
			ext_xfer_read  <= 1'b0;
			ext_xfer_write <= 1'b0;
		end else begin
			xfer_in_1      <= xfer_in;
			xfer_out_1     <= xfer_out;
			xfer_query_1   <= xfer_query;
			// ask the external side to fill endpoint 1
			ext_xfer_read  <= ep1_start;
			ext_xfer_write <= 1'b0;

			case (state)
				st_rst: begin
					sel   <= sel_free;
					state <= st_idle;
				end
				st_idle: begin
					if (in_rise) begin
						sel       <= endp_to_sel(xfer_endp);
						endp_last <= xfer_endp;
						state     <= st_xfer_in;
					end else if (out_rise) begin
						sel       <= endp_to_sel(xfer_endp);
						endp_last <= xfer_endp;
						state     <= st_xfer_out;
					end else if (query_rise) begin
						sel       <= endp_to_sel(xfer_endp);
						endp_last <= xfer_endp;
						state     <= st_query;
					end
				end
				st_xfer_in: begin
					if (!xfer_in) begin
						// endpoint 2 holds fresh host data
						ext_xfer_write <= (sel == sel_ep2);
						state          <= st_done;
					end
				end
				st_xfer_out: begin
					if (!xfer_out) begin
						state <= st_done;
					end
				end
				st_query: begin
					if (!xfer_query) begin
						state <= st_done;
					end
				end
				st_done: begin
					sel   <= sel_free;
					state <= st_idle;
				end
				default: begin
					state <= st_rst;
				end
			endcase
		end
	end

	// endpoint 0 ready latch, set by a finished setup and cleared once
	// the host starts reading the reply
	assign ep0_ready_rise = ep0_xfer_ready & ~ep0_ready_1;

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			ep0_ready_1         <= 1'b0;
			ep0_out_1           <= 1'b0;
			ep0_ready_latch     <= 1'b0;
			err_missed_ep_ready <= 1'b0;
		end else begin
			ep0_ready_1 <= ep0_xfer_ready;
			ep0_out_1   <= ep0_xfer_out;
			if (ep0_ready_rise) begin
				ep0_ready_latch <= 1'b1;
				// previous reply was never fetched
				if (ep0_ready_latch) begin
					err_missed_ep_ready <= 1'b1;
				end
			end else if (ep0_xfer_out && !ep0_out_1) begin
				ep0_ready_latch <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// buffer steering
	//////////////////////////////////////////////////////////////////////

	assign ep0_xfer_in      = (sel == sel_ep0) && xfer_in;
	assign ep0_xfer_out     = (sel == sel_ep0) && xfer_out;
	assign ep0_xfer_pid     = (sel == sel_ep0) ? xfer_pid : 4'h0;
	assign ep0_buf_in_wren  = (sel == sel_ep0) && buf_in_wren;
	assign ep0_buf_out_addr = 8'(buf_out_addr);
	// ack arrives after the strobe, so it goes to the last endpoint
	assign ep0_xfer_out_ok  = xfer_out_ok && (endp_last == ep_ctrl);
	assign ep2_wr_en        = (sel == sel_ep2) && buf_in_wren;

	always_comb begin
		case (sel)
			sel_ep0: begin
				buf_in_ready  = 1'b1;
				buf_out_ready = ep0_ready_latch;
				buf_out_q     = ep0_buf_out_q;
				buf_out_len   = len_w'(ep0_buf_out_len);
			end
			sel_ep1: begin
				buf_in_ready  = ext_buf_in_ready;
				buf_out_ready = ext_buf_out_ready;
				buf_out_q     = ep1_rd_q;
				buf_out_len   = ep1_cnt;
			end
			sel_ep2: begin
				// OUT only, the host has nothing to read here
				buf_in_ready  = ext_buf_in_ready;
				buf_out_ready = ext_buf_out_ready;
				buf_out_q     = 8'h00;
				buf_out_len   = ext_xfer_len;
			end
			default: begin
				buf_in_ready  = 1'b0;
				buf_out_ready = 1'b0;
				buf_out_q     = 8'h00;
				buf_out_len   = '0;
			end
		endcase
	end

	// at most one transaction opens per cycle
	assert property (@(posedge phy_clk) disable iff (!reset_2)
		$onehot0({in_rise, out_rise, query_rise}));

	// packet layer writes host data only to a supported endpoint
	assert property (@(posedge phy_clk) disable iff (!reset_2)
		((state == st_xfer_in) && buf_in_wren) |-> (sel != sel_free));

	// host data ack never shows up inside an IN or PING
	assert property (@(posedge phy_clk) disable iff (!reset_2)
		$rose(xfer_in_ok) |-> !(xfer_out || xfer_query));

	//////////////////////////////////////////////////////////////////////
	// endpoints
	//////////////////////////////////////////////////////////////////////

	usb_ep0 ep0 (
		.phy_clk      (phy_clk),
		.reset_2      (reset_2),
		.xfer_in      (ep0_xfer_in),
		.xfer_out     (ep0_xfer_out),
		.xfer_out_ok  (ep0_xfer_out_ok),
		.xfer_pid     (ep0_xfer_pid),
		.xfer_ready   (ep0_xfer_ready),
		.buf_in_addr  (buf_in_addr[5:0]),
		.buf_in_data  (buf_in_data),
		.buf_in_wren  (ep0_buf_in_wren),
		.buf_out_addr (ep0_buf_out_addr),
		.buf_out_q    (ep0_buf_out_q),
		.buf_out_len  (ep0_buf_out_len),
		.dev_addr     (dev_addr)
	);

	// bulk IN, external side fills and the host reads
	usb_ep_bulk #(
		.buf_aw (buf_aw)
	) ep1 (
		.phy_clk    (phy_clk),
		.reset_2    (reset_2),
		.xfer_start (ep1_start),
		.wr_addr    (ext_buf_in_addr),
		.wr_data    (ext_buf_in_data),
		.wr_en      (ext_buf_in_wren),
		.rd_addr    (buf_out_addr),
		.rd_q       (ep1_rd_q),
		.byte_cnt   (ep1_cnt)
	);

	// bulk OUT, the host fills and the external side reads
	usb_ep_bulk #(
		.buf_aw (buf_aw)
	) ep2 (
		.phy_clk    (phy_clk),
		.reset_2    (reset_2),
		.xfer_start (ep2_start),
		.wr_addr    (buf_in_addr),
		.wr_data    (buf_in_data),
		.wr_en      (ep2_wr_en),
		.rd_addr    (ext_buf_out_addr),
		.rd_q       (ext_buf_out_q),
		.byte_cnt   (ext_xfer_len)
	);

endmodule

//--- usb_ep0.sv
// control endpoint
// captures setup packets, answers GET_DESCRIPTOR for the device
// descriptor and holds the device address set by SET_ADDRESS
module usb_ep0 import usb_pkg::*; (
	input  logic       phy_clk,
	input  logic       reset_2,

	// transaction strobes, already steered to this endpoint
	input  logic       xfer_in,
	input  logic       xfer_out,
	input  logic       xfer_out_ok,
	input  logic [3:0] xfer_pid,
	output logic       xfer_ready,

	// host data
	input  logic [5:0] buf_in_addr,
	input  logic [7:0] buf_in_data,
	input  logic       buf_in_wren,

	// reply data
	input  logic [7:0] buf_out_addr,
	output logic [7:0] buf_out_q,
	output logic [6:0] buf_out_len,

	output logic [6:0] dev_addr
);

	logic [7:0]  setup_buf [setup_len];

	logic        xfer_in_1;
	logic        xfer_out_1;
	logic        xfer_out_ok_1;
	logic        in_rise;
	logic        in_fall;
	logic        out_rise;
	logic        ok_rise;

	logic        setup_wr;
	logic [3:0]  wr_len;
	logic [3:0]  wr_cnt;
	logic        is_setup;

	logic [7:0]  b_request;
	logic [15:0] w_value;
	logic [15:0] w_length;

	logic [6:0]  addr_pend;
	logic        addr_pend_vld;
	logic        addr_armed;

	assign in_rise  = xfer_in & ~xfer_in_1;
	assign in_fall  = ~xfer_in & xfer_in_1;
	assign out_rise = xfer_out & ~xfer_out_1;
	assign ok_rise  = xfer_out_ok & ~xfer_out_ok_1;

	// only setup bytes are kept, data stage writes are dropped
	assign setup_wr = buf_in_wren && xfer_in && (xfer_pid == pid_setup)
		&& (buf_in_addr < setup_len);
	assign wr_len   = buf_in_addr[3:0] + 4'd1;

	// request fields, little endian
	assign b_request = setup_buf[1];
	assign w_value   = {setup_buf[3], setup_buf[2]};
	assign w_length  = {setup_buf[7], setup_buf[6]};

	always_ff @(posedge phy_clk) begin
		if (setup_wr) begin
			setup_buf[buf_in_addr[2:0]] <= buf_in_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// setup decode and address handling
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			xfer_in_1     <= 1'b0;
			xfer_out_1    <= 1'b0;
			xfer_out_ok_1 <= 1'b0;
			wr_cnt        <= '0;
			is_setup      <= 1'b0;
			xfer_ready    <= 1'b0;
			buf_out_len   <= '0;
			addr_pend     <= '0;
			addr_pend_vld <= 1'b0;
			addr_armed    <= 1'b0;
			dev_addr      <= '0;
		end else begin
			xfer_in_1     <= xfer_in;
			xfer_out_1    <= xfer_out;
			xfer_out_ok_1 <= xfer_out_ok;

			if (in_rise) begin
				xfer_ready <= 1'b0;
				is_setup   <= (xfer_pid == pid_setup);
				wr_cnt     <= setup_wr ? wr_len : '0;
			end else if (setup_wr && (wr_len > wr_cnt)) begin
				wr_cnt <= wr_len;
			end

			// complete setup packet, decode the request
			if (in_fall && is_setup && (wr_cnt == setup_len)) begin
				xfer_ready <= 1'b1;
				if ((b_request == req_get_descriptor) && (w_value[15:8] == desc_device)) begin
					buf_out_len <= (w_length < 16'(dev_desc_len)) ?
						w_length[6:0] : 7'(dev_desc_len);
				end else begin
					buf_out_len <= '0;
				end
				addr_pend     <= w_value[6:0];
				addr_pend_vld <= (b_request == req_set_address);
				addr_armed    <= 1'b0;
			end

			// the status stage is an IN, its ack commits the address
			if (out_rise && addr_pend_vld) begin
				addr_armed <= 1'b1;
			end
			if (ok_rise && addr_armed) begin
				dev_addr      <= addr_pend;
				addr_pend_vld <= 1'b0;
				addr_armed    <= 1'b0;
			end
		end
	end

	// descriptor bytes past the reply length read as zero
	always_ff @(posedge phy_clk) begin
		if (buf_out_addr < buf_out_len) begin
			buf_out_q <= dev_desc[buf_out_addr[4:0]];
		end else begin
			buf_out_q <= 8'h00;
		end
	end

	// packet layer never writes a setup packet longer than 8 bytes
	assert property (@(posedge phy_clk) disable iff (!reset_2)
		(xfer_in && buf_in_wren && (xfer_pid == pid_setup)) |-> (buf_in_addr < setup_len));

endmodule

//--- usb_ep_bulk.sv
// bulk endpoint buffer
// byte ram with one write port and one registered read port,
// plus the byte count of the current fill
module usb_ep_bulk #(
	parameter int buf_aw = 9
) (
	input  logic              phy_clk,
	input  logic              reset_2,

	// start of a new fill, clears the count
	input  logic              xfer_start,

	// producer side
	input  logic [buf_aw-1:0] wr_addr,
	input  logic [7:0]        wr_data,
	input  logic              wr_en,

	// consumer side
	input  logic [buf_aw-1:0] rd_addr,
	output logic [7:0]        rd_q,

	output logic [buf_aw:0]   byte_cnt
);

	localparam int depth = 2 ** buf_aw;
	localparam int len_w = buf_aw + 1;

	logic [7:0]       mem [depth];
	logic [len_w-1:0] wr_len;

	// length implied by the current write
	assign wr_len = {1'b0, wr_addr} + 1'b1;

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge phy_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		// old data on a read of the address being written
		rd_q <= mem[rd_addr];
	end

	//////////////////////////////////////////////////////////////////////
	// fill count
	//////////////////////////////////////////////////////////////////////

	// count follows the highest address written since the start,
	// so out of order writes still give the full length
	always_ff @(posedge phy_clk) begin
		if (!reset_2) begin
			byte_cnt <= '0;
		end else if (xfer_start) begin
			// a write on the start cycle already belongs to the new fill
			byte_cnt <= wr_en ? wr_len : '0;
		end else if (wr_en && (wr_len > byte_cnt)) begin
			byte_cnt <= wr_len;
		end
	end

	// an unknown address would corrupt the count and an unknown ram word
	assert property (@(posedge phy_clk) disable iff (!reset_2)
		wr_en |-> !$isunknown(wr_addr));

endmodule

//--- usb_pkg.sv
// usb device protocol definitions
// endpoint numbers, request codes, transfer sizes and the device descriptor
package usb_pkg;

	//////////////////////////////////////////////////////////////////////
	// endpoints
	//////////////////////////////////////////////////////////////////////

	localparam logic [3:0] ep_ctrl     = 4'd0;
	localparam logic [3:0] ep_bulk_in  = 4'd1;
	localparam logic [3:0] ep_bulk_out = 4'd2;

	// owner of the packet layer buffer ports
	typedef enum logic [1:0] {
		sel_free,
		sel_ep0,
		sel_ep1,
		sel_ep2
	} ep_sel_t;

	//////////////////////////////////////////////////////////////////////
	// control transfers
	//////////////////////////////////////////////////////////////////////

	localparam logic [3:0] pid_setup = 4'b1101;

	// bRequest codes
	localparam logic [7:0] req_set_address    = 8'd5;
	localparam logic [7:0] req_get_descriptor = 8'd6;

	// descriptor type, high byte of wValue
	localparam logic [7:0] desc_device = 8'd1;

	// bytes in a setup packet
	localparam int setup_len = 8;

	//////////////////////////////////////////////////////////////////////
	// device descriptor
	//////////////////////////////////////////////////////////////////////

	localparam int dev_desc_len = 18;

	localparam logic [7:0] dev_desc [dev_desc_len] = '{
		8'h12, 8'h01,
		// usb 2.00
		8'h00, 8'h02,
		// class, subclass, protocol defined per interface
		8'h00, 8'h00, 8'h00,
		// ep0 max packet
		8'h40,
		// vendor and product id
		8'h34, 8'h12, 8'h78, 8'h56,
		// device release 1.00
		8'h00, 8'h01,
		// no string descriptors
		8'h00, 8'h00, 8'h00,
		// one configuration
		8'h01
	};

endpackage
